/* verilog/dc_params.svh */
`ifndef DC_PARAMS_SVH
`define DC_PARAMS_SVH

// Byte address and data word widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

// Byte offset inside a word
`define DC_WORD_OFS_W 2
// Byte offset inside a line, four words per line
`define DC_LINE_W 4
// Set index, 16 sets
`define DC_SET_W 4
// Tag is whatever is left above the index
`define DC_TAG_W (`DC_ADDR_W - `DC_LINE_W - `DC_SET_W)
// Word address into a data way, set and word slot together
`define DC_WADDR_W (`DC_SET_W + `DC_LINE_W - `DC_WORD_OFS_W)

`define DC_WAYS 2
`define DC_FIFO_DEPTH 2

`endif

/* verilog/dc_pkg.sv */
`include "dc_params.svh"

package dc_pkg;

   // Request opcodes on the CPU channel
   typedef enum logic [1:0] {
      DC_OP_READ,
      DC_OP_WRITE,
      DC_OP_INVAL
   } dc_op_e;

   // Controller states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_REFILL_REQ,
      ST_REFILL,
      ST_WRITE_REQ,
      ST_INVAL,
      ST_RESPOND
   } dc_state_e;

   // CPU request, bsel picks bytes for writes
   typedef struct packed {
      dc_op_e                   op;
      logic [`DC_ADDR_W-1:0]    addr;
      logic [`DC_DATA_W-1:0]    wdata;
      logic [`DC_DATA_W/8-1:0]  bsel;
   } dc_req_t;

   // CPU response
   typedef struct packed {
      logic [`DC_DATA_W-1:0] rdata;
      logic                  err;
   } dc_rsp_t;

   // Memory request
   // Reads carry a line aligned address
   typedef struct packed {
      logic                     we;
      logic [`DC_ADDR_W-1:0]    addr;
      logic [`DC_DATA_W-1:0]    wdata;
      logic [`DC_DATA_W/8-1:0]  bsel;
   } dc_mem_req_t;

   // One refill beat from memory
   typedef struct packed {
      logic [`DC_DATA_W-1:0] data;
      logic                  err;
   } dc_mem_beat_t;

   // Tag entry of one way
   typedef struct packed {
      logic                 valid;
      logic [`DC_TAG_W-1:0] tag;
   } dc_tag_t;

endpackage

/* verilog/dc_req_fifo.sv */
`include "dc_params.svh"

module dc_req_fifo import dc_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    in_valid_i,
   output logic    in_ready_o,
   input  dc_req_t in_req_i,
   output logic    out_valid_o,
   input  logic    out_ready_i,
   output dc_req_t out_req_o
);

   localparam int PTR_W = $clog2(`DC_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`DC_FIFO_DEPTH + 1);

   // Entry storage, payload only
   dc_req_t          mem [`DC_FIFO_DEPTH];
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W-1:0] wr_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   // Pointer advance with wrap at the last entry
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`DC_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign out_valid_o = (count_q != '0);
   // Full queue still takes a new item when the head leaves this cycle
   assign in_ready_o  = (count_q != CNT_W'(`DC_FIFO_DEPTH)) || out_ready_i;
   assign push        = in_valid_i && in_ready_o;
   assign pop         = out_valid_o && out_ready_i;
   // Head entry straight from storage
   assign out_req_o   = mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= in_req_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         // Count only moves when one side is idle
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

/* verilog/dc_tag_store.sv */
`include "dc_params.svh"

module dc_tag_store import dc_pkg::*; (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [`DC_SET_W-1:0]       rd_index_i,
   input  logic [`DC_TAG_W-1:0]       lookup_tag_i,
   input  logic                       wr_en_i,
   input  logic [`DC_SET_W-1:0]       wr_index_i,
   input  dc_tag_t [`DC_WAYS-1:0]     wr_ways_i,
   input  logic                       wr_lru_i,
   output dc_tag_t [`DC_WAYS-1:0]     rd_ways_o,
   output logic                       rd_lru_o,
   output logic [`DC_WAYS-1:0]        hit_o
);

   localparam int SETS = 1 << `DC_SET_W;

   // Tags live in plain memory
   logic [`DC_TAG_W-1:0]          tag_mem [SETS][`DC_WAYS];
   // Valid and LRU bits in flops so reset clears all sets at once
   logic [SETS-1:0][`DC_WAYS-1:0] valid_q;
   // Way to replace next, per set
   logic [SETS-1:0]               lru_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         lru_q   <= '0;
      end else if (wr_en_i) begin
         for (int w = 0; w < `DC_WAYS; w++) begin
            valid_q[wr_index_i][w] <= wr_ways_i[w].valid;
         end
         lru_q[wr_index_i] <= wr_lru_i;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         for (int w = 0; w < `DC_WAYS; w++) begin
            tag_mem[wr_index_i][w] <= wr_ways_i[w].tag;
         end
      end
   end

   // Synchronous read, one cycle from index to data
   // A write shows up on a read issued the following cycle
   always_ff @(posedge clk) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         rd_ways_o[w].valid <= valid_q[rd_index_i][w];
         rd_ways_o[w].tag   <= tag_mem[rd_index_i][w];
      end
      rd_lru_o <= lru_q[rd_index_i];
   end

   // Hit compare against the held request tag
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         hit_o[w] = rd_ways_o[w].valid && (rd_ways_o[w].tag == lookup_tag_i);
      end
   end

endmodule

/* verilog/dc_way_store.sv */
`include "dc_params.svh"

module dc_way_store (
   input  logic                                clk,
   input  logic [`DC_WADDR_W-1:0]              rd_addr_i,
   output logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] rd_data_o,
   input  logic [`DC_WADDR_W-1:0]              wr_addr_i,
   input  logic [`DC_WAYS-1:0]                 wr_way_i,
   input  logic [`DC_DATA_W/8-1:0]             wr_be_i,
   input  logic [`DC_DATA_W-1:0]               wr_data_i
);

   localparam int WORDS = 1 << `DC_WADDR_W;

   // One word per set and word slot in each way
   logic [`DC_DATA_W-1:0] mem [`DC_WAYS][WORDS];

   always_ff @(posedge clk) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         // Byte lanes merge in place
         for (int b = 0; b < `DC_DATA_W/8; b++) begin
            if (wr_way_i[w] && wr_be_i[b]) begin
               mem[w][wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
            end
         end
         // Both ways read every cycle
         rd_data_o[w] <= mem[w][rd_addr_i];
      end
   end

endmodule

/* verilog/dc_ctrl.sv */
`include "dc_params.svh"

module dc_ctrl import dc_pkg::*; (
   input  logic                                clk,
   input  logic                                rst,
   // Request from the queue
   input  logic                                req_valid_i,
   output logic                                req_ready_o,
   input  dc_req_t                             req_i,
   // Response to the CPU
   output logic                                rsp_valid_o,
   input  logic                                rsp_ready_i,
   output dc_rsp_t                             rsp_o,
   // Memory request and refill beats
   output logic                                mem_req_valid_o,
   input  logic                                mem_req_ready_i,
   output dc_mem_req_t                         mem_req_o,
   input  logic                                mem_rsp_valid_i,
   output logic                                mem_rsp_ready_o,
   input  dc_mem_beat_t                        mem_rsp_i,
   // Tag store
   output logic [`DC_SET_W-1:0]                tag_rd_index_o,
   output logic [`DC_TAG_W-1:0]                tag_lookup_o,
   output logic                                tag_wr_en_o,
   output logic [`DC_SET_W-1:0]                tag_wr_index_o,
   output dc_tag_t [`DC_WAYS-1:0]              tag_wr_ways_o,
   output logic                                tag_wr_lru_o,
   input  dc_tag_t [`DC_WAYS-1:0]              tag_rd_ways_i,
   input  logic                                tag_rd_lru_i,
   input  logic [`DC_WAYS-1:0]                 tag_hit_i,
   // Way store
   output logic [`DC_WADDR_W-1:0]              way_rd_addr_o,
   output logic [`DC_WADDR_W-1:0]              way_wr_addr_o,
   output logic [`DC_WAYS-1:0]                 way_wr_en_o,
   output logic [`DC_DATA_W/8-1:0]             way_wr_be_o,
   output logic [`DC_DATA_W-1:0]               way_wr_data_o,
   input  logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] way_rd_data_i
);

   // Word slot inside a line
   localparam int WSEL_W = `DC_LINE_W - `DC_WORD_OFS_W;

   dc_state_e            state_q;
   // Held request and response
   dc_req_t              req_q;
   dc_rsp_t              rsp_q;
   // Refill beat counter and sticky error
   logic [WSEL_W-1:0]    beat_q;
   logic                 err_q;
   // Way chosen for replacement
   logic                 victim_q;
   dc_req_t              cur_req;
   logic                 hit;
   logic                 last_beat;
   logic [WSEL_W-1:0]    word_sel;
   logic [`DC_SET_W-1:0] set_idx;

   // Stores read the incoming request while idle, else the held one
   assign cur_req        = (state_q == ST_IDLE) ? req_i : req_q;
   assign tag_rd_index_o = cur_req.addr[`DC_LINE_W +: `DC_SET_W];
   assign way_rd_addr_o  = cur_req.addr[`DC_WORD_OFS_W +: `DC_WADDR_W];

   assign set_idx        = req_q.addr[`DC_LINE_W +: `DC_SET_W];
   assign word_sel       = req_q.addr[`DC_WORD_OFS_W +: WSEL_W];
   assign tag_lookup_o   = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
   assign tag_wr_index_o = set_idx;
   assign hit            = |tag_hit_i;
   assign last_beat      = &beat_q;

   // Handshake outputs follow the state
   assign req_ready_o     = (state_q == ST_IDLE);
   assign rsp_valid_o     = (state_q == ST_RESPOND);
   assign rsp_o           = rsp_q;
   assign mem_req_valid_o = (state_q == ST_REFILL_REQ) || (state_q == ST_WRITE_REQ);
   assign mem_rsp_ready_o = (state_q == ST_REFILL);

   // Memory request built from the held request
   always_comb begin
      mem_req_o.we    = (state_q == ST_WRITE_REQ);
      mem_req_o.addr  = req_q.addr;
      mem_req_o.wdata = req_q.wdata;
      mem_req_o.bsel  = req_q.bsel;
      if (!mem_req_o.we) begin
         // Refill asks for the whole line
         mem_req_o.addr[`DC_LINE_W-1:0] = '0;
         mem_req_o.bsel                 = '1;
      end
   end

   // Store writes
   always_comb begin
      tag_wr_en_o   = 1'b0;
      tag_wr_ways_o = tag_rd_ways_i;
      tag_wr_lru_o  = tag_rd_lru_i;
      way_wr_en_o   = '0;
      way_wr_be_o   = req_q.bsel;
      way_wr_data_o = req_q.wdata;
      way_wr_addr_o = req_q.addr[`DC_WORD_OFS_W +: `DC_WADDR_W];
      case (state_q)
         ST_LOOKUP: begin
            if (hit) begin
               // Other way becomes the replacement candidate
               tag_wr_en_o  = 1'b1;
               tag_wr_lru_o = tag_hit_i[0];
               // Write hit also updates the cached word
               if (req_q.op == DC_OP_WRITE) begin
                  way_wr_en_o = tag_hit_i;
               end
            end
         end
         ST_REFILL: begin
            if (mem_rsp_valid_i) begin
               way_wr_en_o[victim_q] = 1'b1;
               way_wr_be_o           = '1;
               way_wr_data_o         = mem_rsp_i.data;
               way_wr_addr_o         = {set_idx, beat_q};
               if (beat_q == '0) begin
                  // Victim goes invalid while it is being overwritten
                  tag_wr_en_o                   = 1'b1;
                  tag_wr_ways_o[victim_q].valid = 1'b0;
               end else if (last_beat && !err_q && !mem_rsp_i.err) begin
                  // Clean refill completes the entry
                  tag_wr_en_o                   = 1'b1;
                  tag_wr_ways_o[victim_q].valid = 1'b1;
                  tag_wr_ways_o[victim_q].tag   = tag_lookup_o;
                  tag_wr_lru_o                  = ~victim_q;
               end
            end
         end
         ST_INVAL: begin
            tag_wr_en_o  = 1'b1;
            tag_wr_lru_o = 1'b0;
            for (int w = 0; w < `DC_WAYS; w++) begin
               tag_wr_ways_o[w].valid = 1'b0;
            end
         end
         default: begin
         end
      endcase
   end

   // FSM
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= ST_IDLE;
         beat_q  <= '0;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_valid_i) begin
                  state_q <= (req_i.op == DC_OP_INVAL) ? ST_INVAL : ST_LOOKUP;
               end
            end
            ST_LOOKUP: begin
               // Writes always go through, misses do not allocate
               if (req_q.op == DC_OP_WRITE) begin
                  state_q <= ST_WRITE_REQ;
               end else if (hit) begin
                  state_q <= ST_RESPOND;
               end else begin
                  state_q <= ST_REFILL_REQ;
               end
            end
            ST_REFILL_REQ: begin
               if (mem_req_ready_i) begin
                  state_q <= ST_REFILL;
                  beat_q  <= '0;
                  err_q   <= 1'b0;
               end
            end
            ST_REFILL: begin
               if (mem_rsp_valid_i) begin
                  beat_q <= beat_q + 1'b1;
                  err_q  <= err_q | mem_rsp_i.err;
                  if (last_beat) begin
                     state_q <= ST_RESPOND;
                  end
               end
            end
            ST_WRITE_REQ: begin
               if (mem_req_ready_i) begin
                  state_q <= ST_RESPOND;
               end
            end
            ST_INVAL: begin
               state_q <= ST_RESPOND;
            end
            ST_RESPOND: begin
               // Hold until the CPU takes it
               if (rsp_ready_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Request, victim and response payload
   always_ff @(posedge clk) begin
      if (req_valid_i && req_ready_o) begin
         req_q <= req_i;
      end
      if (state_q == ST_LOOKUP) begin
         victim_q  <= tag_rd_lru_i;
         rsp_q.err <= 1'b0;
         if (req_q.op == DC_OP_READ && hit) begin
            rsp_q.rdata <= way_rd_data_i[tag_hit_i[1]];
         end else begin
            rsp_q.rdata <= '0;
         end
      end
      if (state_q == ST_INVAL) begin
         rsp_q <= '0;
      end
      if (state_q == ST_REFILL && mem_rsp_valid_i) begin
         // Pick out the requested word as it passes
         if (beat_q == word_sel) begin
            rsp_q.rdata <= mem_rsp_i.data;
         end
         if (last_beat) begin
            rsp_q.err <= err_q | mem_rsp_i.err;
         end
      end
   end

endmodule

/* verilog/dc_top.sv */
`include "dc_params.svh"

module dc_top import dc_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         req_valid_i,
   output logic         req_ready_o,
   input  dc_req_t      req_i,
   output logic         rsp_valid_o,
   input  logic         rsp_ready_i,
   output dc_rsp_t      rsp_o,
   output logic         mem_req_valid_o,
   input  logic         mem_req_ready_i,
   output dc_mem_req_t  mem_req_o,
   input  logic         mem_rsp_valid_i,
   output logic         mem_rsp_ready_o,
   input  dc_mem_beat_t mem_rsp_i
);

   // Queue to controller
   logic                                q_valid;
   logic                                q_ready;
   dc_req_t                             q_req;
   // Tag store
   logic [`DC_SET_W-1:0]                tag_rd_index;
   logic [`DC_TAG_W-1:0]                tag_lookup;
   logic                                tag_wr_en;
   logic [`DC_SET_W-1:0]                tag_wr_index;
   dc_tag_t [`DC_WAYS-1:0]              tag_wr_ways;
   logic                                tag_wr_lru;
   dc_tag_t [`DC_WAYS-1:0]              tag_rd_ways;
   logic                                tag_rd_lru;
   logic [`DC_WAYS-1:0]                 tag_hit;
   // Way store
   logic [`DC_WADDR_W-1:0]              way_rd_addr;
   logic [`DC_WADDR_W-1:0]              way_wr_addr;
   logic [`DC_WAYS-1:0]                 way_wr_en;
   logic [`DC_DATA_W/8-1:0]             way_wr_be;
   logic [`DC_DATA_W-1:0]               way_wr_data;
   logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] way_rd_data;

   dc_req_fifo u_fifo (
      .clk         (clk),
      .rst         (rst),
      .in_valid_i  (req_valid_i),
      .in_ready_o  (req_ready_o),
      .in_req_i    (req_i),
      .out_valid_o (q_valid),
      .out_ready_i (q_ready),
      .out_req_o   (q_req)
   );

   dc_ctrl u_ctrl (
      .clk             (clk),
      .rst             (rst),
      .req_valid_i     (q_valid),
      .req_ready_o     (q_ready),
      .req_i           (q_req),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_ready_i     (rsp_ready_i),
      .rsp_o           (rsp_o),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i),
      .mem_req_o       (mem_req_o),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_ready_o (mem_rsp_ready_o),
      .mem_rsp_i       (mem_rsp_i),
      .tag_rd_index_o  (tag_rd_index),
      .tag_lookup_o    (tag_lookup),
      .tag_wr_en_o     (tag_wr_en),
      .tag_wr_index_o  (tag_wr_index),
      .tag_wr_ways_o   (tag_wr_ways),
      .tag_wr_lru_o    (tag_wr_lru),
      .tag_rd_ways_i   (tag_rd_ways),
      .tag_rd_lru_i    (tag_rd_lru),
      .tag_hit_i       (tag_hit),
      .way_rd_addr_o   (way_rd_addr),
      .way_wr_addr_o   (way_wr_addr),
      .way_wr_en_o     (way_wr_en),
      .way_wr_be_o     (way_wr_be),
      .way_wr_data_o   (way_wr_data),
      .way_rd_data_i   (way_rd_data)
   );

   dc_tag_store u_tags (
      .clk          (clk),
      .rst          (rst),
      .rd_index_i   (tag_rd_index),
      .lookup_tag_i (tag_lookup),
      .wr_en_i      (tag_wr_en),
      .wr_index_i   (tag_wr_index),
      .wr_ways_i    (tag_wr_ways),
      .wr_lru_i     (tag_wr_lru),
      .rd_ways_o    (tag_rd_ways),
      .rd_lru_o     (tag_rd_lru),
      .hit_o        (tag_hit)
   );

   dc_way_store u_ways (
      .clk       (clk),
      .rd_addr_i (way_rd_addr),
      .rd_data_o (way_rd_data),
      .wr_addr_i (way_wr_addr),
      .wr_way_i  (way_wr_en),
      .wr_be_i   (way_wr_be),
      .wr_data_i (way_wr_data)
   );

endmodule

/* sim/tb_clk_gen.sv */
module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // 40 ns period
   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   // Reset held for the first 4 rising edges
   initial begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

/* sim/tb_dc_top.sv */
`include "dc_params.svh"

module tb_dc_top import dc_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SETS       = 1 << `DC_SET_W;
   localparam int MEM_WORDS  = 1024;
   localparam int WAIT_LIMIT = 300;

   // One stimulus row, refills is the expected count of line reads
   typedef struct packed {
      dc_op_e                  op;
      logic [`DC_ADDR_W-1:0]   addr;
      logic [`DC_DATA_W-1:0]   wdata;
      logic [`DC_DATA_W/8-1:0] bsel;
      logic                    inject;
      logic [1:0]              refills;
   } stim_row_t;

   logic         clk;
   logic         rst;
   // DUT inputs start at known values
   logic         req_valid     = 1'b0;
   dc_req_t      req           = '0;
   logic         rsp_ready     = 1'b0;
   logic         mem_req_ready = 1'b0;
   logic         mem_rsp_valid = 1'b0;
   dc_mem_beat_t mem_beat      = '0;
   logic         req_ready;
   logic         rsp_valid;
   dc_rsp_t      rsp;
   logic         mem_req_valid;
   logic         mem_rsp_ready;
   dc_mem_req_t  mem_req;

   logic [31:0]           lfsr_state = 32'he09a_a2a9;
   // Backing memory, 4 KB
   logic [`DC_DATA_W-1:0] mem_words [MEM_WORDS];
   // Memory side bookkeeping
   int                    refill_count  = 0;
   int                    write_count   = 0;
   int                    beat_idx      = 0;
   bit                    refill_active = 1'b0;
   logic                  inject_err    = 1'b0;
   logic [`DC_ADDR_W-1:0] refill_addr;
   dc_mem_req_t           last_wr;
   // Reference model of tags, valids and LRU
   logic                  model_valid [SETS][2];
   logic [`DC_TAG_W-1:0]  model_tag [SETS][2];
   logic                  model_lru [SETS];
   stim_row_t             rows [$];

   tb_clk_gen u_clk_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   dc_top dut (
      .clk             (clk),
      .rst             (rst),
      .req_valid_i     (req_valid),
      .req_ready_o     (req_ready),
      .req_i           (req),
      .rsp_valid_o     (rsp_valid),
      .rsp_ready_i     (rsp_ready),
      .rsp_o           (rsp),
      .mem_req_valid_o (mem_req_valid),
      .mem_req_ready_i (mem_req_ready),
      .mem_req_o       (mem_req),
      .mem_rsp_valid_i (mem_rsp_valid),
      .mem_rsp_ready_o (mem_rsp_ready),
      .mem_rsp_i       (mem_beat)
   );

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic next_rand_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s got=%h exp=%h", name, got, exp);
         $display("SOME TESTS FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic stop_on_timeout(input string what);
      $display("timed out while waiting for %s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "wait limit reached");
   endtask

   task automatic add_row(input dc_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] bsel, input logic inject, input logic [1:0] refills);
      stim_row_t row;
      row.op      = op;
      row.addr    = addr;
      row.wdata   = wdata;
      row.bsel    = bsel;
      row.inject  = inject;
      row.refills = refills;
      rows.push_back(row);
   endtask

   // Memory responder, also owns all random ready and gap decisions
   always @(posedge clk) begin
      if (rst) begin
         mem_req_ready <= 1'b0;
         mem_rsp_valid <= 1'b0;
         rsp_ready     <= 1'b0;
         refill_active = 1'b0;
      end else begin
         // Beat taken on this edge
         if (mem_rsp_valid && mem_rsp_ready) begin
            beat_idx = beat_idx + 1;
            if (beat_idx == 4) begin
               refill_active = 1'b0;
            end
         end
         if (mem_req_valid && mem_req_ready) begin
            if (mem_req.we) begin
               // Write applies byte by byte
               for (int b = 0; b < `DC_DATA_W/8; b++) begin
                  if (mem_req.bsel[b]) begin
                     mem_words[mem_req.addr[11:2]][b*8 +: 8] = mem_req.wdata[b*8 +: 8];
                  end
               end
               last_wr     = mem_req;
               write_count = write_count + 1;
            end else begin
               refill_addr   = mem_req.addr;
               refill_count  = refill_count + 1;
               beat_idx      = 0;
               refill_active = 1'b1;
            end
         end
         // Hold an unaccepted beat, else maybe send the next one
         if (mem_rsp_valid && !mem_rsp_ready) begin
            mem_rsp_valid <= 1'b1;
         end else if (refill_active && next_rand_bit()) begin
            mem_rsp_valid <= 1'b1;
            mem_beat.data <= mem_words[refill_addr[11:2] + 10'(beat_idx)];
            mem_beat.err  <= inject_err && (beat_idx == 0);
         end else begin
            mem_rsp_valid <= 1'b0;
         end
         // Ready about 3 cycles in 4
         mem_req_ready <= next_rand_bit() | next_rand_bit();
         rsp_ready     <= next_rand_bit() | next_rand_bit();
      end
   end

   task automatic send_req(input dc_req_t r);
      int n;
      bit done;
      req       <= r;
      req_valid <= 1'b1;
      n    = 0;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         n = n + 1;
         if (req_ready) begin
            done = 1'b1;
         end else if (n >= WAIT_LIMIT) begin
            stop_on_timeout("the request to be accepted");
         end
      end
      req_valid <= 1'b0;
   endtask

   // rise counts edges from the request transfer to the first valid
   task automatic wait_rsp(output dc_rsp_t r, output int rise);
      int n;
      bit done;
      n    = 0;
      rise = 0;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         n = n + 1;
         if (rsp_valid && rise == 0) begin
            rise = n;
         end
         if (rsp_valid && rsp_ready) begin
            r    = rsp;
            done = 1'b1;
         end else if (n >= WAIT_LIMIT) begin
            stop_on_timeout("the response");
         end
      end
   endtask

   task automatic lookup_model(input logic [31:0] addr, output logic hit, output logic way);
      logic [`DC_SET_W-1:0] s;
      s   = addr[`DC_LINE_W +: `DC_SET_W];
      hit = 1'b0;
      way = 1'b0;
      for (int w = 0; w < 2; w++) begin
         if (model_valid[s][w] && model_tag[s][w] == addr[`DC_ADDR_W-1 -: `DC_TAG_W]) begin
            hit = 1'b1;
            way = w[0];
         end
      end
   endtask

   task automatic run_row(input stim_row_t row);
      dc_req_t              r;
      dc_rsp_t              got;
      int                   refills0;
      int                   writes0;
      int                   rise;
      logic                 hit;
      logic                 hit_way;
      logic                 victim;
      logic [`DC_SET_W-1:0] set_idx;
      set_idx = row.addr[`DC_LINE_W +: `DC_SET_W];
      lookup_model(row.addr, hit, hit_way);
      refills0   = refill_count;
      writes0    = write_count;
      inject_err = row.inject;
      r.op    = row.op;
      r.addr  = row.addr;
      r.wdata = row.wdata;
      r.bsel  = row.bsel;
      send_req(r);
      wait_rsp(got, rise);
      check_val("refills", refill_count - refills0, row.refills);
      case (row.op)
         DC_OP_READ: begin
            check_val("model_refills", !hit, row.refills);
            check_val("writes", write_count - writes0, 0);
            check_val("rsp_err", got.err, row.inject);
            if (!row.inject) begin
               check_val("rsp_rdata", got.rdata, mem_words[row.addr[11:2]]);
            end
            if (hit) begin
               // Queue cycle plus two controller cycles
               check_val("hit_latency", rise, 3);
               model_lru[set_idx] = ~hit_way;
            end else begin
               check_val("refill_addr", refill_addr, {row.addr[31:4], 4'h0});
               victim = model_lru[set_idx];
               if (row.inject) begin
                  model_valid[set_idx][victim] = 1'b0;
               end else begin
                  model_valid[set_idx][victim] = 1'b1;
                  model_tag[set_idx][victim]   = row.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
                  model_lru[set_idx]           = ~victim;
               end
            end
         end
         DC_OP_WRITE: begin
            check_val("writes", write_count - writes0, 1);
            check_val("mem_req_addr", last_wr.addr, row.addr);
            check_val("mem_req_wdata", last_wr.wdata, row.wdata);
            check_val("mem_req_bsel", last_wr.bsel, row.bsel);
            check_val("rsp_rdata", got.rdata, 0);
            check_val("rsp_err", got.err, 0);
            // No allocation on a write miss
            if (hit) begin
               model_lru[set_idx] = ~hit_way;
            end
         end
         default: begin
            check_val("writes", write_count - writes0, 0);
            check_val("inval_latency", rise, 3);
            check_val("rsp_rdata", got.rdata, 0);
            check_val("rsp_err", got.err, 0);
            model_valid[set_idx][0] = 1'b0;
            model_valid[set_idx][1] = 1'b0;
            model_lru[set_idx]      = 1'b0;
         end
      endcase
   endtask

   initial begin
      int n;
      // Each word holds its own byte address scrambled
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_words[i] = (32'(i) << 2) ^ 32'h5a3c_96e1;
      end
      for (int s = 0; s < SETS; s++) begin
         model_valid[s][0] = 1'b0;
         model_valid[s][1] = 1'b0;
         model_tag[s][0]   = '0;
         model_tag[s][1]   = '0;
         model_lru[s]      = 1'b0;
      end

      // Reads, first access of a line refills
      add_row(DC_OP_READ,  32'h0000_0104, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0104, 32'h0,         4'h0, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_010c, 32'h0,         4'h0, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_0230, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0238, 32'h0,         4'h0, 1'b0, 2'd0);
      // Write hit, write miss, then reads of the merged words
      add_row(DC_OP_WRITE, 32'h0000_0104, 32'hdead_beef, 4'h3, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_0104, 32'h0,         4'h0, 1'b0, 2'd0);
      add_row(DC_OP_WRITE, 32'h0000_0554, 32'h1234_5678, 4'hc, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_0554, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_WRITE, 32'h0000_0558, 32'ha5a5_a5a5, 4'hf, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_0558, 32'h0,         4'h0, 1'b0, 2'd0);
      // Set 6 with lines A B C, C evicts B
      add_row(DC_OP_READ,  32'h0000_0060, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0164, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0068, 32'h0,         4'h0, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_026c, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0060, 32'h0,         4'h0, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_0160, 32'h0,         4'h0, 1'b0, 2'd1);
      // Invalidate set 6, other sets keep their lines
      add_row(DC_OP_INVAL, 32'h0000_0060, 32'h0,         4'h0, 1'b0, 2'd0);
      add_row(DC_OP_READ,  32'h0000_0060, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0164, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_0108, 32'h0,         4'h0, 1'b0, 2'd0);
      // Refill error leaves the line uncached
      add_row(DC_OP_READ,  32'h0000_03a0, 32'h0,         4'h0, 1'b1, 2'd1);
      add_row(DC_OP_READ,  32'h0000_03a0, 32'h0,         4'h0, 1'b0, 2'd1);
      add_row(DC_OP_READ,  32'h0000_03a4, 32'h0,         4'h0, 1'b0, 2'd0);

      // Outputs idle during reset and right after it
      @(posedge clk);
      n = 0;
      do begin
         @(negedge clk);
         check_val("rsp_valid_o", rsp_valid, 0);
         check_val("mem_req_valid_o", mem_req_valid, 0);
         check_val("mem_rsp_ready_o", mem_rsp_ready, 0);
         n = n + 1;
         if (n >= WAIT_LIMIT) begin
            stop_on_timeout("reset to be released");
         end
      end while (rst);
      check_val("req_ready_o", req_ready, 1);

      @(posedge clk);
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* src.f */
+incdir+verilog
verilog/dc_pkg.sv
verilog/dc_req_fifo.sv
verilog/dc_tag_store.sv
verilog/dc_way_store.sv
verilog/dc_ctrl.sv
verilog/dc_top.sv
sim/tb_clk_gen.sv
sim/tb_dc_top.sv

/* Bender.yml */
package:
  name: dc_cache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dc_pkg.sv
      - verilog/dc_req_fifo.sv
      - verilog/dc_tag_store.sv
      - verilog/dc_way_store.sv
      - verilog/dc_ctrl.sv
      - verilog/dc_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_dc_top.sv
